// File: common/bp_addr_pkg.sv
package bp_addr_pkg;

    parameter int XLEN        = 32;
    parameter int BYTE_OFFSET = 2;    // Word aligned PCs, low bits ignored
    parameter int INSTR_BYTES = 4;

    typedef logic [XLEN-1:0] addr_t;

    // Bits left for the tag once index and byte offset are taken
    function automatic int tag_width(input int index_width);
        return XLEN - index_width - BYTE_OFFSET;
    endfunction

    // Fall-through address of a branch
    function automatic addr_t pc_next(input addr_t pc);
        return pc + addr_t'(INSTR_BYTES);
    endfunction

endpackage

// File: common/bp_state_pkg.sv
package bp_state_pkg;

    // 2-bit saturating counter, MSB is the taken prediction
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_state_e;

    // Why the front end has to be redirected
    typedef enum logic [1:0] {
        REDIR_NONE      = 2'b00,
        REDIR_DIRECTION = 2'b01,   // Taken bit was wrong
        REDIR_TARGET    = 2'b10    // Taken both times, different target
    } redirect_e;

endpackage

// File: common/btb_if.sv
`timescale 1ns/1ps

interface btb_if
    import bp_addr_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
);

    localparam int TAG_WIDTH = tag_width(INDEX_WIDTH);

    // Read side, combinational
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [TAG_WIDTH-1:0]   rd_tag;
    logic                   rd_hit;
    addr_t                  rd_target;

    // Write side, lands on the next rising edge
    logic                   wr_en;
    logic [INDEX_WIDTH-1:0] wr_index;
    logic [TAG_WIDTH-1:0]   wr_tag;
    addr_t                  wr_target;

    modport lookup_mp (
        output rd_index, rd_tag,
        input  rd_hit, rd_target
    );

    modport resolve_mp (
        output wr_en, wr_index, wr_tag, wr_target
    );

    modport table_mp (
        input  rd_index, rd_tag, wr_en, wr_index, wr_tag, wr_target,
        output rd_hit, rd_target
    );

endinterface

// File: design/gshare_predictor_top.sv
`timescale 1ns/1ps

module gshare_predictor_top
    import bp_addr_pkg::*;
    import bp_state_pkg::*;
#(
    parameter int INDEX_WIDTH   = 6,
    parameter int HISTORY_WIDTH = 5
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Lookup request
    input  logic                     lookup_valid_i,
    input  addr_t                    lookup_pc_i,

    // Resolution from execute
    input  logic                     update_valid_i,
    input  addr_t                    update_pc_i,
    input  logic                     update_taken_i,
    input  addr_t                    update_target_i,
    input  logic [HISTORY_WIDTH-1:0] update_ghr_i,
    input  logic                     update_pred_taken_i,
    input  addr_t                    update_pred_target_i,

    // Prediction result
    output logic                     pred_valid_o,
    output addr_t                    pred_pc_o,
    output logic                     pred_taken_o,
    output addr_t                    pred_target_o,
    output logic [HISTORY_WIDTH-1:0] pred_ghr_o,

    // Redirect
    output logic                     mispredict_o,
    output addr_t                    redirect_pc_o,
    output redirect_e                redirect_cause_o
);

    logic [HISTORY_WIDTH-1:0] ghr;
    addr_t                    pht_rd_pc;
    ctr_state_e               ctr_state;
    logic                     pht_wr_en;
    addr_t                    pht_wr_pc;
    logic [HISTORY_WIDTH-1:0] pht_wr_ghr;
    logic                     pht_wr_taken;

    btb_if #(.INDEX_WIDTH(INDEX_WIDTH)) btb ();

    lookup_stage #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) u_lookup (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lookup_valid_i (lookup_valid_i),
        .lookup_pc_i    (lookup_pc_i),
        .ghr_i          (ghr),
        .ctr_state_i    (ctr_state),
        .btb            (btb.lookup_mp),
        .pht_pc_o       (pht_rd_pc),
        .pred_valid_o   (pred_valid_o),
        .pred_pc_o      (pred_pc_o),
        .pred_taken_o   (pred_taken_o),
        .pred_target_o  (pred_target_o),
        .pred_ghr_o     (pred_ghr_o)
    );

    resolve_stage #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) u_resolve (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .update_valid_i       (update_valid_i),
        .update_pc_i          (update_pc_i),
        .update_taken_i       (update_taken_i),
        .update_target_i      (update_target_i),
        .update_ghr_i         (update_ghr_i),
        .update_pred_taken_i  (update_pred_taken_i),
        .update_pred_target_i (update_pred_target_i),
        .btb                  (btb.resolve_mp),
        .ghr_o                (ghr),
        .pht_wr_en_o          (pht_wr_en),
        .pht_wr_pc_o          (pht_wr_pc),
        .pht_wr_ghr_o         (pht_wr_ghr),
        .pht_wr_taken_o       (pht_wr_taken),
        .mispredict_o         (mispredict_o),
        .redirect_pc_o        (redirect_pc_o),
        .redirect_cause_o     (redirect_cause_o)
    );

    btb_table #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_btb (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .btb    (btb.table_mp)
    );

    // Read side hashed with the live GHR
    pht_table #(
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) u_pht (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_pc_i    (pht_rd_pc),
        .rd_ghr_i   (ghr),
        .wr_en_i    (pht_wr_en),
        .wr_pc_i    (pht_wr_pc),
        .wr_ghr_i   (pht_wr_ghr),
        .wr_taken_i (pht_wr_taken),
        .rd_state_o (ctr_state)
    );

endmodule

// File: design/lookup_stage.sv
`timescale 1ns/1ps

module lookup_stage
    import bp_addr_pkg::*;
    import bp_state_pkg::*;
#(
    parameter int INDEX_WIDTH   = 6,
    parameter int HISTORY_WIDTH = 5
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     lookup_valid_i,
    input  addr_t                    lookup_pc_i,
    input  logic [HISTORY_WIDTH-1:0] ghr_i,
    input  ctr_state_e               ctr_state_i,
    btb_if.lookup_mp                 btb,
    output addr_t                    pht_pc_o,
    output logic                     pred_valid_o,
    output addr_t                    pred_pc_o,
    output logic                     pred_taken_o,
    output addr_t                    pred_target_o,
    output logic [HISTORY_WIDTH-1:0] pred_ghr_o
);

    logic  taken_d;
    addr_t target_d;

    // Split the PC for the BTB, whole PC goes to the PHT hash
    assign btb.rd_index = lookup_pc_i[INDEX_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];
    assign btb.rd_tag   = lookup_pc_i[XLEN-1:INDEX_WIDTH+BYTE_OFFSET];
    assign pht_pc_o     = lookup_pc_i;

    // Taken needs both a known target and a taken counter
    assign taken_d  = btb.rd_hit && ctr_state_i[1];
    assign target_d = btb.rd_hit ? btb.rd_target : pc_next(lookup_pc_i);

    // Single-cycle result pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= lookup_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_valid_i) begin
            pred_pc_o     <= lookup_pc_i;
            pred_taken_o  <= taken_d;
            pred_target_o <= target_d;
            pred_ghr_o    <= ghr_i;   // Snapshot returned with the update
        end
    end

endmodule

// File: design/resolve_stage.sv
`timescale 1ns/1ps

module resolve_stage
    import bp_addr_pkg::*;
    import bp_state_pkg::*;
#(
    parameter int INDEX_WIDTH   = 6,
    parameter int HISTORY_WIDTH = 5
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     update_valid_i,
    input  addr_t                    update_pc_i,
    input  logic                     update_taken_i,
    input  addr_t                    update_target_i,
    input  logic [HISTORY_WIDTH-1:0] update_ghr_i,
    input  logic                     update_pred_taken_i,
    input  addr_t                    update_pred_target_i,
    btb_if.resolve_mp                btb,
    output logic [HISTORY_WIDTH-1:0] ghr_o,
    output logic                     pht_wr_en_o,
    output addr_t                    pht_wr_pc_o,
    output logic [HISTORY_WIDTH-1:0] pht_wr_ghr_o,
    output logic                     pht_wr_taken_o,
    output logic                     mispredict_o,
    output addr_t                    redirect_pc_o,
    output redirect_e                redirect_cause_o
);

    logic                     valid_q;
    addr_t                    pc_q;
    logic                     taken_q;
    addr_t                    target_q;
    logic [HISTORY_WIDTH-1:0] ghr_snap_q;
    logic                     pred_taken_q;
    addr_t                    pred_target_q;
    logic [HISTORY_WIDTH-1:0] ghr_q;
    redirect_e                cause;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= update_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_valid_i) begin
            pc_q          <= update_pc_i;
            taken_q       <= update_taken_i;
            target_q      <= update_target_i;
            ghr_snap_q    <= update_ghr_i;
            pred_taken_q  <= update_pred_taken_i;
            pred_target_q <= update_pred_target_i;
        end
    end

    // Direction check first, target only matters when both say taken
    always_comb begin
        cause = REDIR_NONE;
        if (valid_q) begin
            if (taken_q != pred_taken_q) begin
                cause = REDIR_DIRECTION;
            end else if (taken_q && (target_q != pred_target_q)) begin
                cause = REDIR_TARGET;
            end
        end
    end

    assign mispredict_o     = (cause != REDIR_NONE);
    assign redirect_cause_o = cause;
    assign redirect_pc_o    = taken_q ? target_q : pc_next(pc_q);

    // Training writes, land at the next edge
    assign pht_wr_en_o    = valid_q;
    assign pht_wr_pc_o    = pc_q;
    assign pht_wr_ghr_o   = ghr_snap_q;   // Same index the prediction used
    assign pht_wr_taken_o = taken_q;

    assign btb.wr_en     = valid_q && taken_q;   // Only taken branches allocate
    assign btb.wr_index  = pc_q[INDEX_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];
    assign btb.wr_tag    = pc_q[XLEN-1:INDEX_WIDTH+BYTE_OFFSET];
    assign btb.wr_target = target_q;

    // Non-speculative history, shifts with the table writes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (valid_q) begin
            ghr_q <= {ghr_q[HISTORY_WIDTH-2:0], taken_q};
        end
    end

    assign ghr_o = ghr_q;

endmodule

// File: gshare_predictor_top.f
common/bp_addr_pkg.sv
common/bp_state_pkg.sv
common/btb_if.sv
predictor/btb_table.sv
predictor/pht_table.sv
design/lookup_stage.sv
design/resolve_stage.sv
design/gshare_predictor_top.sv
tb/bp_checker.sv
tb/tb_gshare.sv

// File: predictor/btb_table.sv
`timescale 1ns/1ps

module btb_table
    import bp_addr_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    btb_if.table_mp    btb
);

    localparam int DEPTH     = 2 ** INDEX_WIDTH;
    localparam int TAG_WIDTH = tag_width(INDEX_WIDTH);

    logic [DEPTH-1:0]     valid_q;
    logic [TAG_WIDTH-1:0] tag_q    [DEPTH];
    addr_t                target_q [DEPTH];

    logic                 rd_valid;
    logic                 rd_tag_match;

    // Combinational read port
    assign rd_valid      = valid_q[btb.rd_index];
    assign rd_tag_match  = (tag_q[btb.rd_index] == btb.rd_tag);
    assign btb.rd_hit    = rd_valid && rd_tag_match;
    assign btb.rd_target = target_q[btb.rd_index];

    // Valid bits, all entries empty after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (btb.wr_en) begin
            valid_q[btb.wr_index] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk_i) begin
        if (btb.wr_en) begin
            tag_q[btb.wr_index]    <= btb.wr_tag;
            target_q[btb.wr_index] <= btb.wr_target;   // Latest target wins
        end
    end

endmodule

// File: predictor/pht_table.sv
`timescale 1ns/1ps

module pht_table
    import bp_addr_pkg::*;
    import bp_state_pkg::*;
#(
    parameter int HISTORY_WIDTH = 5
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  addr_t                    rd_pc_i,
    input  logic [HISTORY_WIDTH-1:0] rd_ghr_i,
    input  logic                     wr_en_i,
    input  addr_t                    wr_pc_i,
    input  logic [HISTORY_WIDTH-1:0] wr_ghr_i,
    input  logic                     wr_taken_i,
    output ctr_state_e               rd_state_o
);

    localparam int DEPTH = 2 ** HISTORY_WIDTH;

    ctr_state_e               ctr_q [DEPTH];
    logic [HISTORY_WIDTH-1:0] rd_idx;
    logic [HISTORY_WIDTH-1:0] wr_idx;

    // Gshare hash, PC word bits folded with history
    function automatic logic [HISTORY_WIDTH-1:0] pht_index(
        input addr_t                    pc,
        input logic [HISTORY_WIDTH-1:0] ghr
    );
        return pc[HISTORY_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET] ^ ghr;
    endfunction

    // One step toward the outcome, saturating at both ends
    function automatic ctr_state_e ctr_step(input ctr_state_e s, input logic taken);
        ctr_state_e nxt;
        nxt = s;
        case (s)
            CTR_STRONG_NT: nxt = taken ? CTR_WEAK_NT  : CTR_STRONG_NT;
            CTR_WEAK_NT:   nxt = taken ? CTR_WEAK_T   : CTR_STRONG_NT;
            CTR_WEAK_T:    nxt = taken ? CTR_STRONG_T : CTR_WEAK_NT;
            CTR_STRONG_T:  nxt = taken ? CTR_STRONG_T : CTR_WEAK_T;
            default:       nxt = CTR_WEAK_NT;
        endcase
        return nxt;
    endfunction

    assign rd_idx     = pht_index(rd_pc_i, rd_ghr_i);
    assign wr_idx     = pht_index(wr_pc_i, wr_ghr_i);
    assign rd_state_o = ctr_q[rd_idx];   // Old value until the write edge

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (wr_en_i) begin
            ctr_q[wr_idx] <= ctr_step(ctr_q[wr_idx], wr_taken_i);
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the gshare predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --top-module tb_gshare --Mdir "$OBJ" -o sim_gshare \
    -f gshare_predictor_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_gshare" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

# Verdict comes from the log
if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: tb/bp_checker.sv
`timescale 1ns/1ps

module bp_checker
    import bp_addr_pkg::*;
    import bp_state_pkg::*;
#(
    parameter int INDEX_WIDTH   = 6,
    parameter int HISTORY_WIDTH = 5
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     lookup_valid_i,
    input  addr_t                    lookup_pc_i,
    input  logic                     update_valid_i,
    input  addr_t                    update_pc_i,
    input  logic                     update_taken_i,
    input  addr_t                    update_target_i,
    input  logic [HISTORY_WIDTH-1:0] update_ghr_i,
    input  logic                     update_pred_taken_i,
    input  addr_t                    update_pred_target_i,
    input  logic                     pred_valid_i,
    input  addr_t                    pred_pc_i,
    input  logic                     pred_taken_i,
    input  addr_t                    pred_target_i,
    input  logic [HISTORY_WIDTH-1:0] pred_ghr_i,
    input  logic                     mispredict_i,
    input  addr_t                    redirect_pc_i,
    input  redirect_e                redirect_cause_i,
    input  logic                     done_i,
    output int                       error_count_o
);

    localparam int BTB_DEPTH = 2 ** INDEX_WIDTH;
    localparam int PHT_DEPTH = 2 ** HISTORY_WIDTH;
    localparam int TAGW      = 30 - INDEX_WIDTH;

    // Reference tables
    logic [1:0]               ctr_m        [PHT_DEPTH];
    logic                     btb_valid_m  [BTB_DEPTH];
    logic [TAGW-1:0]          btb_tag_m    [BTB_DEPTH];
    addr_t                    btb_target_m [BTB_DEPTH];
    logic [HISTORY_WIDTH-1:0] ghr_m;

    // Update sampled at the last edge and applied at the next one
    logic                     pend_valid;
    addr_t                    pend_pc;
    logic                     pend_taken;
    addr_t                    pend_target;
    logic [HISTORY_WIDTH-1:0] pend_ghr;

    logic                     exp_pred_valid;
    addr_t                    exp_pc;
    logic                     exp_taken;
    addr_t                    exp_target;
    logic [HISTORY_WIDTH-1:0] exp_ghr;
    logic                     exp_upd;
    redirect_e                exp_cause;
    addr_t                    exp_redirect;

    logic [INDEX_WIDTH-1:0]   bidx;
    logic [HISTORY_WIDTH-1:0] hidx;
    logic                     hit;

    int value_errs = 0;
    int pulse_errs = 0;
    int n_preds    = 0;
    int n_updates  = 0;

    assign error_count_o = value_errs + pulse_errs;

    function automatic logic [1:0] saturate_step(input logic [1:0] c, input logic t);
        if (t) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    task automatic flag_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        value_errs++;
        $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    endtask

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                ctr_m[i] = 2'b01;   // Weak not taken
            end
            for (int i = 0; i < BTB_DEPTH; i++) begin
                btb_valid_m[i] = 1'b0;
            end
            ghr_m          = '0;
            pend_valid     = 1'b0;
            exp_pred_valid = 1'b0;
            exp_upd        = 1'b0;
        end else begin
            // Prediction sees the tables before this edge's training
            exp_pred_valid = lookup_valid_i;
            if (lookup_valid_i) begin
                bidx       = lookup_pc_i[INDEX_WIDTH+1:2];
                hidx       = lookup_pc_i[HISTORY_WIDTH+1:2] ^ ghr_m;
                hit        = btb_valid_m[bidx] &&
                             (btb_tag_m[bidx] == lookup_pc_i[31:INDEX_WIDTH+2]);
                exp_pc     = lookup_pc_i;
                exp_taken  = hit && ctr_m[hidx][1];
                exp_target = hit ? btb_target_m[bidx] : lookup_pc_i + 32'd4;
                exp_ghr    = ghr_m;
            end
            if (pend_valid) begin
                hidx        = pend_pc[HISTORY_WIDTH+1:2] ^ pend_ghr;
                ctr_m[hidx] = saturate_step(ctr_m[hidx], pend_taken);
                if (pend_taken) begin
                    bidx               = pend_pc[INDEX_WIDTH+1:2];
                    btb_valid_m[bidx]  = 1'b1;
                    btb_tag_m[bidx]    = pend_pc[31:INDEX_WIDTH+2];
                    btb_target_m[bidx] = pend_target;
                end
                ghr_m = {ghr_m[HISTORY_WIDTH-2:0], pend_taken};
            end
            pend_valid  = update_valid_i;
            pend_pc     = update_pc_i;
            pend_taken  = update_taken_i;
            pend_target = update_target_i;
            pend_ghr    = update_ghr_i;
            exp_upd     = update_valid_i;
            exp_cause   = REDIR_NONE;
            if (update_taken_i != update_pred_taken_i) begin
                exp_cause = REDIR_DIRECTION;
            end else if (update_taken_i && (update_target_i != update_pred_target_i)) begin
                exp_cause = REDIR_TARGET;
            end
            exp_redirect = update_taken_i ? update_target_i : update_pc_i + 32'd4;
        end
    end

    // Compare mid-cycle against the model
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (exp_pred_valid && !pred_valid_i) begin
                pulse_errs++;
                $display("No prediction pulse for the lookup of PC 0x%08h at %0t", exp_pc, $time);
            end else if (!exp_pred_valid && pred_valid_i) begin
                pulse_errs++;
                $display("Prediction pulse without a lookup at %0t", $time);
            end else if (exp_pred_valid) begin
                n_preds++;
                if (pred_pc_i !== exp_pc) flag_value("pred_pc_o", pred_pc_i, exp_pc);
                if (pred_taken_i !== exp_taken) begin
                    flag_value("pred_taken_o", 32'(pred_taken_i), 32'(exp_taken));
                end
                if (pred_target_i !== exp_target) begin
                    flag_value("pred_target_o", pred_target_i, exp_target);
                end
                if (pred_ghr_i !== exp_ghr) begin
                    flag_value("pred_ghr_o", 32'(pred_ghr_i), 32'(exp_ghr));
                end
            end
            if (exp_upd) begin
                n_updates++;
                if ((exp_cause != REDIR_NONE) && !mispredict_i) begin
                    pulse_errs++;
                    $display("Mispredict pulse missing for PC 0x%08h at %0t", pend_pc, $time);
                end else if ((exp_cause == REDIR_NONE) && mispredict_i) begin
                    pulse_errs++;
                    $display("Mispredict raised for a correct prediction at %0t", $time);
                end
                if (redirect_cause_i !== exp_cause) begin
                    flag_value("redirect_cause_o", 32'(redirect_cause_i), 32'(exp_cause));
                end
                if (redirect_pc_i !== exp_redirect) begin
                    flag_value("redirect_pc_o", redirect_pc_i, exp_redirect);
                end
            end else if (mispredict_i !== 1'b0) begin
                pulse_errs++;
                $display("Mispredict raised without an update at %0t", $time);
            end
        end
    end

    always @(posedge done_i) begin
        $display("Checked %0d predictions and %0d updates: %0d value errors, %0d pulse errors",
                 n_preds, n_updates, value_errs, pulse_errs);
    end

endmodule

// File: tb/tb_gshare.sv
`timescale 1ns/1ps

module tb_gshare
    import bp_addr_pkg::*;
    import bp_state_pkg::*;
();

    localparam int INDEX_WIDTH   = 6;
    localparam int HISTORY_WIDTH = 5;
    localparam int NUM_OPS       = 400;
    localparam int POOL          = 8;
    localparam int WATCHDOG_CYC  = NUM_OPS * 4 + 50;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     lookup_valid_i;
    addr_t                    lookup_pc_i;
    logic                     update_valid_i;
    addr_t                    update_pc_i;
    logic                     update_taken_i;
    addr_t                    update_target_i;
    logic [HISTORY_WIDTH-1:0] update_ghr_i;
    logic                     update_pred_taken_i;
    addr_t                    update_pred_target_i;
    logic                     pred_valid_o;
    addr_t                    pred_pc_o;
    logic                     pred_taken_o;
    addr_t                    pred_target_o;
    logic [HISTORY_WIDTH-1:0] pred_ghr_o;
    logic                     mispredict_o;
    addr_t                    redirect_pc_o;
    redirect_e                redirect_cause_o;

    logic done;
    int   error_count;
    int   seed = 23;

    addr_t pool_pc    [POOL];
    addr_t cur_target [POOL];

    // Branches in flight between lookup and resolution
    logic                     slot_valid       [4];
    int                       slot_k           [4];
    logic                     slot_pred_taken  [4];
    addr_t                    slot_pred_target [4];
    logic [HISTORY_WIDTH-1:0] slot_ghr         [4];

    gshare_predictor_top #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) DUT (.*);

    bp_checker #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) u_checker (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .lookup_valid_i       (lookup_valid_i),
        .lookup_pc_i          (lookup_pc_i),
        .update_valid_i       (update_valid_i),
        .update_pc_i          (update_pc_i),
        .update_taken_i       (update_taken_i),
        .update_target_i      (update_target_i),
        .update_ghr_i         (update_ghr_i),
        .update_pred_taken_i  (update_pred_taken_i),
        .update_pred_target_i (update_pred_target_i),
        .pred_valid_i         (pred_valid_o),
        .pred_pc_i            (pred_pc_o),
        .pred_taken_i         (pred_taken_o),
        .pred_target_i        (pred_target_o),
        .pred_ghr_i           (pred_ghr_o),
        .mispredict_i         (mispredict_o),
        .redirect_pc_i        (redirect_pc_o),
        .redirect_cause_i     (redirect_cause_o),
        .done_i               (done),
        .error_count_o        (error_count)
    );

    // Taken chance in eighths for each pool entry
    function automatic int taken_bias(input int k);
        case (k)
            0: return 8;
            1: return 7;
            2: return 6;
            3: return 4;
            4: return 2;
            5: return 1;
            6: return 0;
            default: return 5;
        endcase
    endfunction

    task automatic drive_lookup(input int s);
        int r;
        r = $random(seed);
        slot_valid[s]  = (r[2:0] != 3'd0);   // About one idle cycle in eight
        slot_k[s]      = (r >> 3) & 7;
        lookup_valid_i = slot_valid[s];
        lookup_pc_i    = pool_pc[slot_k[s]];
    endtask

    task automatic capture_prediction(input int s);
        slot_pred_taken[s]  = pred_taken_o;
        slot_pred_target[s] = pred_target_o;
        slot_ghr[s]         = pred_ghr_o;
    endtask

    task automatic drive_update(input int s);
        int k;
        int r;
        k = slot_k[s];
        update_valid_i = slot_valid[s];
        if (slot_valid[s]) begin
            r = $random(seed);
            if ((r & 31) == 0) begin
                cur_target[k] = cur_target[k] ^ 32'h40;   // Moved target
            end
            update_pc_i          = pool_pc[k];
            update_taken_i       = ((r >> 5) & 7) < taken_bias(k);
            update_target_i      = cur_target[k];
            update_ghr_i         = slot_ghr[s];
            update_pred_taken_i  = slot_pred_taken[s];
            update_pred_target_i = slot_pred_target[s];
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_i);
        $display("Timeout after %0d clock periods, the run did not finish", WATCHDOG_CYC);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst_ni               = 1'b0;
        done                 = 1'b0;
        lookup_valid_i       = 1'b0;
        lookup_pc_i          = '0;
        update_valid_i       = 1'b0;
        update_pc_i          = '0;
        update_taken_i       = 1'b0;
        update_target_i      = '0;
        update_ghr_i         = '0;
        update_pred_taken_i  = 1'b0;
        update_pred_target_i = '0;
        pool_pc[0] = 32'h0000_1000;
        pool_pc[1] = 32'h0000_1004;
        pool_pc[2] = 32'h0000_1048;
        pool_pc[3] = 32'h0000_2010;
        pool_pc[4] = 32'h0000_3014;
        pool_pc[5] = 32'h0000_10c8;
        pool_pc[6] = 32'h0000_4000;   // Same BTB set as entry 0 with another tag
        pool_pc[7] = 32'h0000_20fc;
        for (int i = 0; i < POOL; i++) begin
            cur_target[i] = addr_t'(32'h8000 + i * 256);
        end
        for (int i = 0; i < 4; i++) begin
            slot_valid[i] = 1'b0;
            slot_k[i]     = 0;
        end
        repeat (3) @(posedge clk_i);
        #2 rst_ni = 1'b1;

        // Lookup every cycle and resolve three cycles later
        for (int cyc = 0; cyc < NUM_OPS + 4; cyc++) begin
            @(posedge clk_i);
            #2;
            if (cyc >= 1) capture_prediction((cyc - 1) % 4);
            if (cyc >= 3) begin
                drive_update((cyc - 3) % 4);
            end
            if (cyc < NUM_OPS) begin
                drive_lookup(cyc % 4);
            end else begin
                lookup_valid_i     = 1'b0;
                slot_valid[cyc % 4] = 1'b0;
            end
        end
        update_valid_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #2 done = 1'b1;
        #1;
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
